//--- isa_pkg.sv
package isa_pkg;

    localparam int word_width = 32;

    // Opcode field of the instruction word
    localparam int opcode_msb = 31;
    localparam int opcode_lsb = 27;

    // Dropped opcodes are left out and decode as illegal
    typedef enum logic [4:0] {
        op_ld   = 5'd0,
        op_ldi  = 5'd1,
        op_st   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd5,
        op_or   = 5'd6,
        op_ror  = 5'd7,
        op_rol  = 5'd8,
        op_shr  = 5'd9,
        op_shra = 5'd10,
        op_shl  = 5'd11,
        op_addi = 5'd12,
        op_andi = 5'd13,
        op_ori  = 5'd14,
        op_neg  = 5'd17,
        op_not  = 5'd18,
        op_br   = 5'd19,
        op_jal  = 5'd20,
        op_jr   = 5'd21,
        op_nop  = 5'd26,
        op_halt = 5'd27
    } opcode_t;

    typedef enum logic [3:0] {
        alu_and  = 4'd0,
        alu_or   = 4'd1,
        alu_not  = 4'd2,
        alu_add  = 4'd3,
        alu_sub  = 4'd4,
        alu_shl  = 4'd7,
        alu_shr  = 4'd8,
        alu_rol  = 4'd9,
        alu_ror  = 4'd10,
        alu_neg  = 4'd11,
        alu_shra = 4'd12
    } alu_op_t;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [2:0] {
        ph_reset,
        ph_fetch0,
        ph_fetch1,
        ph_fetch2,
        ph_execute,
        ph_halted
    } phase_t;

    typedef enum logic [3:0] {
        cls_load,
        cls_load_imm,
        cls_store,
        cls_alu_reg,
        cls_alu_unary,
        cls_alu_imm,
        cls_branch,
        cls_jump_reg,
        cls_jump_link,
        cls_nop,
        cls_halt,
        cls_illegal
    } instr_class_t;

    // Internal bus sources still in use
    typedef enum logic [4:0] {
        bus_none = 5'd0,
        bus_zlow = 5'd19,
        bus_pc   = 5'd20,
        bus_mdr  = 5'd21,
        bus_imm  = 5'd23
    } bus_sel_t;

    localparam int step_width = 3;
    typedef logic [step_width-1:0] step_t;

    // Execute cycles per class in instr_class_t order
    // halt and illegal never enter execute
    localparam step_t exec_length [0:11] = '{
        3'd5, 3'd3, 3'd4, 3'd3, 3'd2, 3'd3,
        3'd4, 3'd1, 3'd2, 3'd1, 3'd0, 3'd0
    };

endpackage

//--- opcode_decoder.sv
`timescale 1ns/10ps

module opcode_decoder (
    input  isa_pkg::opcode_t        opcode,
    output ctrl_pkg::instr_class_t  instr_class,
    output isa_pkg::alu_op_t        alu_op
);

    always_comb begin
        instr_class = ctrl_pkg::cls_illegal;
        alu_op      = isa_pkg::alu_and;
        case (opcode)
            // Address and branch target arithmetic all add
            isa_pkg::op_ld: begin
                instr_class = ctrl_pkg::cls_load;
                alu_op      = isa_pkg::alu_add;
            end
            isa_pkg::op_ldi: begin
                instr_class = ctrl_pkg::cls_load_imm;
                alu_op      = isa_pkg::alu_add;
            end
            isa_pkg::op_st: begin
                instr_class = ctrl_pkg::cls_store;
                alu_op      = isa_pkg::alu_add;
            end
            isa_pkg::op_br: begin
                instr_class = ctrl_pkg::cls_branch;
                alu_op      = isa_pkg::alu_add;
            end

            isa_pkg::op_add:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_add};
            isa_pkg::op_sub:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_sub};
            isa_pkg::op_and:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_and};
            isa_pkg::op_or:   {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_or};
            isa_pkg::op_ror:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_ror};
            isa_pkg::op_rol:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_rol};
            isa_pkg::op_shr:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_shr};
            isa_pkg::op_shra: {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_shra};
            isa_pkg::op_shl:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_reg, isa_pkg::alu_shl};

            isa_pkg::op_neg:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_unary, isa_pkg::alu_neg};
            isa_pkg::op_not:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_unary, isa_pkg::alu_not};

            isa_pkg::op_addi: {instr_class, alu_op} = {ctrl_pkg::cls_alu_imm, isa_pkg::alu_add};
            isa_pkg::op_andi: {instr_class, alu_op} = {ctrl_pkg::cls_alu_imm, isa_pkg::alu_and};
            isa_pkg::op_ori:  {instr_class, alu_op} = {ctrl_pkg::cls_alu_imm, isa_pkg::alu_or};

            // No ALU use so the and code stays
            isa_pkg::op_jr:   instr_class = ctrl_pkg::cls_jump_reg;
            isa_pkg::op_jal:  instr_class = ctrl_pkg::cls_jump_link;
            isa_pkg::op_nop:  instr_class = ctrl_pkg::cls_nop;
            isa_pkg::op_halt: instr_class = ctrl_pkg::cls_halt;
            default: begin
                instr_class = ctrl_pkg::cls_illegal;
                alu_op      = isa_pkg::alu_and;
            end
        endcase
    end

endmodule

//--- step_sequencer.sv
`timescale 1ns/10ps

module step_sequencer (
    input  logic                    Clock,
    input  logic                    Reset,
    input  logic                    stop,
    input  ctrl_pkg::instr_class_t  class_next,
    input  isa_pkg::alu_op_t        alu_op_next,
    output ctrl_pkg::phase_t        phase,
    output ctrl_pkg::instr_class_t  instr_class,
    output isa_pkg::alu_op_t        alu_op_cur,
    output ctrl_pkg::step_t         step
);

    logic last_step;

    assign last_step = (step == ctrl_pkg::step_t'(ctrl_pkg::exec_length[instr_class] - 1));

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            phase       <= ctrl_pkg::ph_reset;
            instr_class <= ctrl_pkg::cls_nop;
            alu_op_cur  <= isa_pkg::alu_and;
            step        <= '0;
        end else if (stop) begin
            // Stop wins over any pending transition
            phase <= ctrl_pkg::ph_halted;
            step  <= '0;
        end else begin
            case (phase)
                ctrl_pkg::ph_reset:  phase <= ctrl_pkg::ph_fetch0;
                ctrl_pkg::ph_fetch0: phase <= ctrl_pkg::ph_fetch1;
                ctrl_pkg::ph_fetch1: phase <= ctrl_pkg::ph_fetch2;
                ctrl_pkg::ph_fetch2: begin
                    // ir holds the new instruction at this edge
                    instr_class <= class_next;
                    alu_op_cur  <= alu_op_next;
                    step        <= '0;
                    case (class_next)
                        ctrl_pkg::cls_halt:    phase <= ctrl_pkg::ph_halted;
                        ctrl_pkg::cls_illegal: phase <= ctrl_pkg::ph_fetch0;
                        default:               phase <= ctrl_pkg::ph_execute;
                    endcase
                end
                ctrl_pkg::ph_execute: begin
                    if (last_step) begin
                        phase <= ctrl_pkg::ph_fetch0;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                // Left only by Reset
                ctrl_pkg::ph_halted: phase <= ctrl_pkg::ph_halted;
                default:             phase <= ctrl_pkg::ph_fetch0;
            endcase
        end
    end

    assert property (@(posedge Clock) disable iff (Reset)
        phase == ctrl_pkg::ph_execute |-> step < ctrl_pkg::exec_length[instr_class]);

    // Halt and illegal must bypass execute entirely
    assert property (@(posedge Clock) disable iff (Reset)
        phase == ctrl_pkg::ph_execute |->
            !(instr_class inside {ctrl_pkg::cls_illegal, ctrl_pkg::cls_halt}));

endmodule

//--- control_word_gen.sv
`timescale 1ns/10ps

module control_word_gen (
    input  ctrl_pkg::phase_t        phase,
    input  ctrl_pkg::instr_class_t  instr_class,
    input  isa_pkg::alu_op_t        alu_op_cur,
    input  ctrl_pkg::step_t         step,
    input  logic                    con_out,
    output logic gra, grb, grc, r_in, r_out, ba_out,
    output logic mdr_en, mar_en, mdr_read, ram_read, ram_write,
    output logic pc_en, ir_en, y_en, z_en, con_en, inc_pc, imm_sel,
    output logic clear, run,
    output isa_pkg::alu_op_t        alu_op,
    output ctrl_pkg::bus_sel_t      bus_sel
);

    always_comb begin
        {gra, grb, grc, r_in, r_out, ba_out} = '0;
        {mdr_en, mar_en, mdr_read, ram_read, ram_write} = '0;
        {pc_en, ir_en, y_en, z_en, con_en, inc_pc, imm_sel} = '0;
        clear   = 1'b0;
        run     = 1'b1;
        alu_op  = isa_pkg::alu_and;
        bus_sel = ctrl_pkg::bus_none;

        case (phase)
            ctrl_pkg::ph_reset:  clear = 1'b1;
            ctrl_pkg::ph_halted: run = 1'b0;
            ctrl_pkg::ph_fetch0: begin
                bus_sel = ctrl_pkg::bus_pc;
                mar_en  = 1'b1;
                inc_pc  = 1'b1;
                z_en    = 1'b1;
            end
            ctrl_pkg::ph_fetch1: begin
                ram_read = 1'b1;
                mdr_read = 1'b1;
                mdr_en   = 1'b1;
            end
            ctrl_pkg::ph_fetch2: begin
                bus_sel = ctrl_pkg::bus_mdr;
                ir_en   = 1'b1;
            end
            ctrl_pkg::ph_execute: begin
                case (instr_class)
                    ctrl_pkg::cls_load, ctrl_pkg::cls_load_imm, ctrl_pkg::cls_store,
                    ctrl_pkg::cls_alu_imm: begin
                        case (step)
                            3'd0: begin
                                // Base register onto bus with r0 read as zero via ba_out
                                grb    = 1'b1;
                                ba_out = (instr_class != ctrl_pkg::cls_alu_imm);
                                r_out  = (instr_class == ctrl_pkg::cls_alu_imm);
                                y_en   = 1'b1;
                            end
                            3'd1: begin
                                imm_sel = 1'b1;
                                z_en    = 1'b1;
                                bus_sel = ctrl_pkg::bus_imm;
                                alu_op  = alu_op_cur;
                            end
                            3'd2: begin
                                bus_sel = ctrl_pkg::bus_zlow;
                                if (instr_class inside {ctrl_pkg::cls_load,
                                                        ctrl_pkg::cls_store}) begin
                                    mar_en = 1'b1;
                                end else begin
                                    gra  = 1'b1;
                                    r_in = 1'b1;
                                end
                            end
                            3'd3: begin
                                mdr_en = 1'b1;
                                if (instr_class == ctrl_pkg::cls_store) begin
                                    gra       = 1'b1;
                                    r_out     = 1'b1;
                                    ram_write = 1'b1;
                                end else begin
                                    ram_read = 1'b1;
                                    mdr_read = 1'b1;
                                end
                            end
                            3'd4: begin
                                gra     = 1'b1;
                                r_in    = 1'b1;
                                bus_sel = ctrl_pkg::bus_mdr;
                            end
                            default: ;
                        endcase
                    end
                    ctrl_pkg::cls_alu_reg: begin
                        case (step)
                            3'd0: begin
                                grb   = 1'b1;
                                r_out = 1'b1;
                                y_en  = 1'b1;
                            end
                            3'd1: begin
                                grc    = 1'b1;
                                r_out  = 1'b1;
                                z_en   = 1'b1;
                                alu_op = alu_op_cur;
                            end
                            3'd2: begin
                                gra     = 1'b1;
                                r_in    = 1'b1;
                                bus_sel = ctrl_pkg::bus_zlow;
                            end
                            default: ;
                        endcase
                    end
                    ctrl_pkg::cls_alu_unary: begin
                        if (step == 3'd0) begin
                            grb    = 1'b1;
                            r_out  = 1'b1;
                            z_en   = 1'b1;
                            alu_op = alu_op_cur;
                        end else begin
                            gra     = 1'b1;
                            r_in    = 1'b1;
                            bus_sel = ctrl_pkg::bus_zlow;
                        end
                    end
                    ctrl_pkg::cls_branch: begin
                        case (step)
                            3'd0: begin
                                gra    = 1'b1;
                                r_out  = 1'b1;
                                con_en = 1'b1;
                            end
                            3'd1: begin
                                y_en    = 1'b1;
                                bus_sel = ctrl_pkg::bus_pc;
                            end
                            3'd2: begin
                                imm_sel = 1'b1;
                                z_en    = 1'b1;
                                bus_sel = ctrl_pkg::bus_imm;
                                alu_op  = isa_pkg::alu_add;
                            end
                            3'd3: begin
                                // Target in Z is taken only if the condition held
                                if (con_out) begin
                                    pc_en   = 1'b1;
                                    bus_sel = ctrl_pkg::bus_zlow;
                                end
                            end
                            default: ;
                        endcase
                    end
                    ctrl_pkg::cls_jump_reg: begin
                        gra   = 1'b1;
                        r_out = 1'b1;
                        pc_en = 1'b1;
                    end
                    ctrl_pkg::cls_jump_link: begin
                        // Return address comes from pc and step 1 idles
                        if (step == 3'd0) begin
                            gra     = 1'b1;
                            r_in    = 1'b1;
                            pc_en   = 1'b1;
                            bus_sel = ctrl_pkg::bus_pc;
                        end
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic                              Clock,
    input  logic                              Reset,
    input  logic                              stop,
    input  logic                              con_out,
    input  logic [isa_pkg::word_width-1:0]    ir,
    output logic gra, grb, grc, r_in, r_out, ba_out,
    output logic mdr_en, mar_en, mdr_read, ram_read, ram_write,
    output logic pc_en, ir_en, y_en, z_en, con_en, inc_pc, imm_sel,
    output logic clear, run,
    output isa_pkg::alu_op_t                  alu_op,
    output ctrl_pkg::bus_sel_t                bus_sel
);

    ctrl_pkg::instr_class_t class_next;
    isa_pkg::alu_op_t       alu_op_next;
    ctrl_pkg::phase_t       phase;
    ctrl_pkg::instr_class_t instr_class;
    isa_pkg::alu_op_t       alu_op_cur;
    ctrl_pkg::step_t        step;

    opcode_decoder opcode_decoder_i (
        .opcode      (isa_pkg::opcode_t'(ir[isa_pkg::opcode_msb:isa_pkg::opcode_lsb])),
        .instr_class (class_next),
        .alu_op      (alu_op_next)
    );

    step_sequencer step_sequencer_i (
        .Clock       (Clock),
        .Reset       (Reset),
        .stop        (stop),
        .class_next  (class_next),
        .alu_op_next (alu_op_next),
        .phase       (phase),
        .instr_class (instr_class),
        .alu_op_cur  (alu_op_cur),
        .step        (step)
    );

    control_word_gen control_word_gen_i (
        .phase (phase), .instr_class (instr_class), .alu_op_cur (alu_op_cur),
        .step (step), .con_out (con_out),
        .gra (gra), .grb (grb), .grc (grc), .r_in (r_in), .r_out (r_out), .ba_out (ba_out),
        .mdr_en (mdr_en), .mar_en (mar_en), .mdr_read (mdr_read),
        .ram_read (ram_read), .ram_write (ram_write),
        .pc_en (pc_en), .ir_en (ir_en), .y_en (y_en), .z_en (z_en), .con_en (con_en),
        .inc_pc (inc_pc), .imm_sel (imm_sel), .clear (clear), .run (run),
        .alu_op (alu_op), .bus_sel (bus_sel)
    );

    // Memory and register file each see one direction per cycle
    assert property (@(posedge Clock) disable iff (Reset) !(ram_read && ram_write));
    assert property (@(posedge Clock) disable iff (Reset) !(r_in && r_out));

endmodule

//--- tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;
int timeout_count = 0;

task automatic check_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
endtask

task automatic check_alu_op(input string name, input isa_pkg::alu_op_t actual,
                            input isa_pkg::alu_op_t expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
endtask

task automatic check_bus_sel(input string name, input ctrl_pkg::bus_sel_t actual,
                             input ctrl_pkg::bus_sel_t expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("Fail %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
endtask

`endif

//--- tb_control_unit.sv
`timescale 1ns/10ps

module tb_control_unit;

    logic Clock;
    logic Reset;
    logic stop;
    logic con_out;
    logic [isa_pkg::word_width-1:0] ir;
    logic gra, grb, grc, r_in, r_out, ba_out;
    logic mdr_en, mar_en, mdr_read, ram_read, ram_write;
    logic pc_en, ir_en, y_en, z_en, con_en, inc_pc, imm_sel;
    logic clear, run;
    isa_pkg::alu_op_t   alu_op;
    ctrl_pkg::bus_sel_t bus_sel;
    logic [19:0] ctrl_word;

    // Index is the bit position in ctrl_word
    string sig_name [0:19] = '{"run", "clear", "imm_sel", "inc_pc", "con_en",
                               "z_en", "y_en", "ir_en", "pc_en", "ram_write",
                               "ram_read", "mdr_read", "mar_en", "mdr_en", "ba_out",
                               "r_out", "r_in", "grc", "grb", "gra"};

    localparam logic [19:0] m_run       = 20'h00001;
    localparam logic [19:0] m_clear     = 20'h00002;
    localparam logic [19:0] m_imm_sel   = 20'h00004;
    localparam logic [19:0] m_inc_pc    = 20'h00008;
    localparam logic [19:0] m_con_en    = 20'h00010;
    localparam logic [19:0] m_z_en      = 20'h00020;
    localparam logic [19:0] m_y_en      = 20'h00040;
    localparam logic [19:0] m_ir_en     = 20'h00080;
    localparam logic [19:0] m_pc_en     = 20'h00100;
    localparam logic [19:0] m_ram_write = 20'h00200;
    localparam logic [19:0] m_ram_read  = 20'h00400;
    localparam logic [19:0] m_mdr_read  = 20'h00800;
    localparam logic [19:0] m_mar_en    = 20'h01000;
    localparam logic [19:0] m_mdr_en    = 20'h02000;
    localparam logic [19:0] m_ba_out    = 20'h04000;
    localparam logic [19:0] m_r_out     = 20'h08000;
    localparam logic [19:0] m_r_in      = 20'h10000;
    localparam logic [19:0] m_grc       = 20'h20000;
    localparam logic [19:0] m_grb       = 20'h40000;
    localparam logic [19:0] m_gra       = 20'h80000;

    assign ctrl_word = {gra, grb, grc, r_in, r_out, ba_out, mdr_en, mar_en, mdr_read,
                        ram_read, ram_write, pc_en, ir_en, y_en, z_en, con_en, inc_pc,
                        imm_sel, clear, run};

    control_unit control_unit_i (.*);

    `include "tb_checks.svh"

    always #10 Clock = ~Clock;

    // Compare a little after the falling edge, once driven inputs have settled
    task automatic expect_word(input logic [19:0] mask, input isa_pkg::alu_op_t alu,
                               input ctrl_pkg::bus_sel_t bus);
        #2;
        for (int i = 0; i < 20; i++) begin
            check_bit(sig_name[i], ctrl_word[i], mask[i]);
        end
        check_alu_op("alu_op", alu_op, alu);
        check_bus_sel("bus_sel", bus_sel, bus);
    endtask

    task automatic cycle_word(input logic [19:0] mask, input isa_pkg::alu_op_t alu,
                              input ctrl_pkg::bus_sel_t bus);
        @(negedge Clock);
        expect_word(mask, alu, bus);
    endtask

    task automatic cycle_plain(input logic [19:0] mask);
        cycle_word(mask, isa_pkg::alu_and, ctrl_pkg::bus_none);
    endtask

    task automatic end_fetch;
        cycle_word(m_run | m_mar_en | m_inc_pc | m_z_en, isa_pkg::alu_and, ctrl_pkg::bus_pc);
        cycle_plain(m_run | m_ram_read | m_mdr_read | m_mdr_en);
    endtask

    // Waits for fetch2 and presents the opcode with a random operand
    task automatic issue(input logic [4:0] opcode);
        int waited;
        logic [26:0] operand;
        waited = 0;
        @(negedge Clock);
        while (!ir_en && waited < 10) begin
            @(negedge Clock);
            waited++;
        end
        if (!ir_en) begin
            timeout_count++;
            $display("Timed out waiting for ir_en before opcode %0d", opcode);
        end
        operand = 27'($urandom);
        ir = {opcode, operand};
        expect_word(m_run | m_ir_en, isa_pkg::alu_and, ctrl_pkg::bus_mdr);
    endtask

    task automatic reset_and_check;
        @(negedge Clock);
        Reset = 1'b1;
        expect_word(m_run | m_clear, isa_pkg::alu_and, ctrl_pkg::bus_none);
        repeat (4) cycle_plain(m_run | m_clear);
        @(negedge Clock);
        Reset = 1'b0;
        // Still in reset phase until the next rising edge
        expect_word(m_run | m_clear, isa_pkg::alu_and, ctrl_pkg::bus_none);
        end_fetch;
    endtask

    task automatic offset_steps(input logic [19:0] base_out, input isa_pkg::alu_op_t alu);
        cycle_plain(m_run | m_grb | base_out | m_y_en);
        cycle_word(m_run | m_imm_sel | m_z_en, alu, ctrl_pkg::bus_imm);
    endtask

    task automatic run_alu_reg(input isa_pkg::opcode_t op, input isa_pkg::alu_op_t alu);
        issue(op);
        cycle_plain(m_run | m_grb | m_r_out | m_y_en);
        cycle_word(m_run | m_grc | m_r_out | m_z_en, alu, ctrl_pkg::bus_none);
        cycle_word(m_run | m_gra | m_r_in, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
        end_fetch;
    endtask

    task automatic run_alu_unary(input isa_pkg::opcode_t op, input isa_pkg::alu_op_t alu);
        issue(op);
        cycle_word(m_run | m_grb | m_r_out | m_z_en, alu, ctrl_pkg::bus_none);
        cycle_word(m_run | m_gra | m_r_in, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
        end_fetch;
    endtask

    task automatic run_alu_imm(input isa_pkg::opcode_t op, input isa_pkg::alu_op_t alu);
        issue(op);
        offset_steps(m_r_out, alu);
        cycle_word(m_run | m_gra | m_r_in, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
        end_fetch;
    endtask

    task automatic test_alu_ops;
        run_alu_reg(isa_pkg::op_add, isa_pkg::alu_add);
        run_alu_reg(isa_pkg::op_sub, isa_pkg::alu_sub);
        run_alu_reg(isa_pkg::op_and, isa_pkg::alu_and);
        run_alu_reg(isa_pkg::op_or, isa_pkg::alu_or);
        run_alu_reg(isa_pkg::op_ror, isa_pkg::alu_ror);
        run_alu_reg(isa_pkg::op_rol, isa_pkg::alu_rol);
        run_alu_reg(isa_pkg::op_shr, isa_pkg::alu_shr);
        run_alu_reg(isa_pkg::op_shra, isa_pkg::alu_shra);
        run_alu_reg(isa_pkg::op_shl, isa_pkg::alu_shl);
        run_alu_unary(isa_pkg::op_neg, isa_pkg::alu_neg);
        run_alu_unary(isa_pkg::op_not, isa_pkg::alu_not);
        run_alu_imm(isa_pkg::op_addi, isa_pkg::alu_add);
        run_alu_imm(isa_pkg::op_andi, isa_pkg::alu_and);
        run_alu_imm(isa_pkg::op_ori, isa_pkg::alu_or);
    endtask

    task automatic test_memory;
        repeat (2) begin
            issue(isa_pkg::op_ld);
            offset_steps(m_ba_out, isa_pkg::alu_add);
            cycle_word(m_run | m_mar_en, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
            cycle_plain(m_run | m_ram_read | m_mdr_read | m_mdr_en);
            cycle_word(m_run | m_gra | m_r_in, isa_pkg::alu_and, ctrl_pkg::bus_mdr);
            end_fetch;
            issue(isa_pkg::op_ldi);
            offset_steps(m_ba_out, isa_pkg::alu_add);
            cycle_word(m_run | m_gra | m_r_in, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
            end_fetch;
            issue(isa_pkg::op_st);
            offset_steps(m_ba_out, isa_pkg::alu_add);
            cycle_word(m_run | m_mar_en, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
            cycle_plain(m_run | m_gra | m_r_out | m_ram_write | m_mdr_en);
            end_fetch;
        end
    endtask

    task automatic test_branch_jump;
        for (int taken = 0; taken < 2; taken++) begin
            issue(isa_pkg::op_br);
            cycle_plain(m_run | m_gra | m_r_out | m_con_en);
            cycle_word(m_run | m_y_en, isa_pkg::alu_and, ctrl_pkg::bus_pc);
            cycle_word(m_run | m_imm_sel | m_z_en, isa_pkg::alu_add, ctrl_pkg::bus_imm);
            @(negedge Clock);
            con_out = (taken == 1);
            if (taken == 1)
                expect_word(m_run | m_pc_en, isa_pkg::alu_and, ctrl_pkg::bus_zlow);
            else
                expect_word(m_run, isa_pkg::alu_and, ctrl_pkg::bus_none);
            end_fetch;
        end
        issue(isa_pkg::op_jr);
        cycle_plain(m_run | m_gra | m_r_out | m_pc_en);
        end_fetch;
        issue(isa_pkg::op_jal);
        cycle_word(m_run | m_gra | m_r_in | m_pc_en, isa_pkg::alu_and, ctrl_pkg::bus_pc);
        cycle_plain(m_run);
        end_fetch;
    endtask

    task automatic test_illegal_nop;
        // Former mul encoding
        issue(5'd15);
        end_fetch;
        issue(isa_pkg::op_nop);
        cycle_plain(m_run);
        end_fetch;
    endtask

    task automatic test_halt_stop;
        issue(isa_pkg::op_halt);
        repeat (4) cycle_plain('0);
        reset_and_check;
        issue(isa_pkg::op_add);
        cycle_plain(m_run | m_grb | m_r_out | m_y_en);
        @(negedge Clock);
        stop = 1'b1;
        expect_word(m_run | m_grc | m_r_out | m_z_en, isa_pkg::alu_add, ctrl_pkg::bus_none);
        @(negedge Clock);
        stop = 1'b0;
        expect_word('0, isa_pkg::alu_and, ctrl_pkg::bus_none);
        repeat (3) cycle_plain('0);
    endtask

    initial begin
        Clock = 1'b0;
        Reset = 1'b1;
        stop = 1'b0;
        con_out = 1'b0;
        ir = '0;
        void'($urandom(32'hab5b_5450));
        reset_and_check;
        test_alu_ops;
        test_memory;
        test_branch_jump;
        test_illegal_nop;
        test_halt_stop;
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
opcode_decoder.sv
step_sequencer.sv
control_word_gen.sv
control_unit.sv
tb_control_unit.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - isa_pkg.sv
  - ctrl_pkg.sv
  - opcode_decoder.sv
  - step_sequencer.sv
  - control_word_gen.sv
  - control_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_control_unit.sv
